//--- Bender.yml
package:
  name: spi_master

sources:
  - design/spi_pkg.sv
  - design/spi_cmd_port.sv
  - design/spi_clk_div.sv
  - design/spi_shift_engine.sv
  - design/spi_rx_port.sv
  - design/spi_master.sv
  - target: test
    files:
      - tb/spi_slave_model.sv
      - tb/tb_spi_master.sv

//--- all.f
design/spi_pkg.sv
design/spi_cmd_port.sv
design/spi_clk_div.sv
design/spi_shift_engine.sv
design/spi_rx_port.sv
design/spi_master.sv
tb/spi_slave_model.sv
tb/tb_spi_master.sv

//--- design/spi_clk_div.sv
module spi_clk_div
    import spi_pkg::*;
(
    input  logic               wr,         // System clock.
    input  logic               rst,        // Asynchronous reset, active high.
    input  logic               div_run,    // Count while high, hold at zero while low.
    input  logic [PRESC_W-1:0] div_presc,  // Exponent of the half-period length.
    output logic               half_tick   // One-cycle pulse per sck half-period.
);

    ////////////////////////////////////////////////////////////////////////////
    // Terminal count decode

    // The half-period is 2**(presc+1) cycles, so the counter runs from zero
    // up to 2**(presc+1)-1. The span is one bit wider than the counter,
    // because exponent 7 gives a span of 256.
    logic [DIV_CNT_W:0]   span;
    logic [DIV_CNT_W-1:0] term_cnt;  // Last count value of a half-period.
    logic [DIV_CNT_W-1:0] cnt;       // Cycles into the current half-period.
    logic                 at_term;

    assign span     = (DIV_CNT_W + 1)'(2) << div_presc;  // Two shifted by presc.
    assign term_cnt = DIV_CNT_W'(span - 1'b1);
    assign at_term  = (cnt == term_cnt);

    ////////////////////////////////////////////////////////////////////////////
    // Counter

    // half_tick is registered. With div_run rising at cycle s, the counter hits
    // the terminal count at s+2**(presc+1)-1 and the tick shows one cycle
    // later. Ticks then repeat every 2**(presc+1) cycles.
    always_ff @(posedge wr or posedge rst) begin
        if (rst) begin
            cnt       <= '0;
            half_tick <= 1'b0;
        end else begin
            half_tick <= div_run && at_term;  // No tick once the engine stops.

            if (!div_run || at_term) begin
                cnt <= '0;                    // Restart for each half-period.
            end else begin
                cnt <= cnt + 1'b1;
            end
        end
    end

    // The exponent comes from the engine's own copy of the command, so it does
    // not move while a frame is running and the count never skips past the
    // terminal value.
    //
    // Between frames the counter sits at zero. Every frame therefore starts
    // with a full first half-period, whatever the previous exponent was.

endmodule

//--- design/spi_cmd_port.sv
module spi_cmd_port
    import spi_pkg::*;
(
    input  logic     wr,         // System clock.
    input  logic     rst,        // Asynchronous reset, active high.
    input  logic     cmd_req,    // Host request, four-phase.
    input  spi_cmd_t cmd,        // Command, stable while cmd_req is high.
    output logic     cmd_ack,    // Acknowledge back to the host.
    output logic     cmd_valid,  // The slot holds a command.
    output spi_cmd_t held_cmd,   // The command waiting for the engine.
    input  logic     cmd_take    // Engine loads held_cmd on this edge.
);

    ////////////////////////////////////////////////////////////////////////////
    // Acceptance state

    // The acked state is also where the port waits for the request to fall,
    // so a new command needs a full return to zero first.
    typedef enum logic {
        acc_idle,   // Waiting for a request.
        acc_acked   // Ack is high, waiting for cmd_req to drop.
    } acc_state_t;

    acc_state_t acc_state;
    logic       slot_full;  // One command is held.
    logic       accept;     // Copy cmd into the slot on this edge.
    spi_cmd_t   cmd_q;      // Holding register for the command.

    // A request is only taken into an empty slot. While the slot is full the
    // ack is withheld, and that is the only back-pressure the host sees.
    assign accept = (acc_state == acc_idle) && cmd_req && !slot_full;

    always_ff @(posedge wr or posedge rst) begin
        if (rst) begin
            acc_state <= acc_idle;
            slot_full <= 1'b0;
        end else begin
            case (acc_state)
                acc_idle: begin
                    if (accept) begin
                        acc_state <= acc_acked;  // Ack shows on the next cycle.
                    end
                end
                acc_acked: begin
                    if (!cmd_req) begin
                        acc_state <= acc_idle;   // Host released, drop the ack.
                    end
                end
                default: acc_state <= acc_idle;
            endcase

            // Filling and emptying never meet, since accept needs an empty slot
            // and the engine only takes from a full one.
            if (accept) begin
                slot_full <= 1'b1;
            end else if (cmd_take) begin
                slot_full <= 1'b0;
            end
        end
    end

    // The command is written only when a request is accepted.
    always_ff @(posedge wr) begin
        if (accept) begin
            cmd_q <= cmd;
        end
    end

    assign cmd_ack   = (acc_state == acc_acked);
    assign cmd_valid = slot_full;
    assign held_cmd  = cmd_q;

endmodule

//--- design/spi_master.sv
module spi_master
    import spi_pkg::*;
(
    input  logic     wr,       // System clock.
    input  logic     rst,      // Asynchronous reset, active high.
    input  logic     cmd_req,  // Host command request.
    input  spi_cmd_t cmd,      // Host command.
    output logic     cmd_ack,  // Command accepted.
    output logic     rx_req,   // Received word on offer.
    input  logic     rx_ack,   // Host took the received word.
    output word_t    rx_data,  // Received word.
    output logic     ss,       // SPI slave select, active low.
    output logic     sck,      // SPI clock.
    output logic     mosi,     // SPI master out.
    input  logic     miso      // SPI master in.
);

    // Command slot to engine.
    logic               cmd_valid;
    logic               cmd_take;
    spi_cmd_t           held_cmd;
    // Engine to divider.
    logic               div_run;
    logic [PRESC_W-1:0] div_presc;
    logic               half_tick;
    // Engine to receive slot.
    logic               rx_load;
    word_t              rx_word;
    logic               rx_full;

    ////////////////////////////////////////////////////////////////////////////
    // Blocks

    spi_cmd_port u_cmd_port (
        .wr        (wr),        .rst       (rst),
        .cmd_req   (cmd_req),   .cmd       (cmd),
        .cmd_ack   (cmd_ack),   .cmd_valid (cmd_valid),
        .held_cmd  (held_cmd),  .cmd_take  (cmd_take)
    );

    spi_clk_div u_clk_div (
        .wr        (wr),        .rst       (rst),
        .div_run   (div_run),   .div_presc (div_presc),
        .half_tick (half_tick)
    );

    spi_shift_engine u_engine (
        .wr        (wr),        .rst       (rst),
        .cmd_valid (cmd_valid), .held_cmd  (held_cmd),  .cmd_take  (cmd_take),
        .rx_full   (rx_full),   .rx_load   (rx_load),   .rx_word   (rx_word),
        .div_run   (div_run),   .div_presc (div_presc), .half_tick (half_tick),
        .ss        (ss),        .sck       (sck),       .mosi      (mosi),
        .miso      (miso)
    );

    spi_rx_port u_rx_port (
        .wr        (wr),        .rst       (rst),
        .rx_load   (rx_load),   .rx_word   (rx_word),   .rx_full   (rx_full),
        .rx_req    (rx_req),    .rx_ack    (rx_ack),    .rx_data   (rx_data)
    );

endmodule

//--- design/spi_pkg.sv
package spi_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Sizes

    localparam int WORD_LEN  = 8;  // Bits per SPI word.
    localparam int PRESC_W   = 3;  // Prescaler exponent width, exponents 0 to 7.
    localparam int DIV_CNT_W = 8;  // Half-period counter, covers up to 256 cycles.

    // One frame is two half-periods per bit. The low bit of the half-period
    // index is the edge phase and the bits above it count data bits.
    localparam int HALF_CNT_W = $clog2(2 * WORD_LEN);

    ////////////////////////////////////////////////////////////////////////////
    // Types

    // One SPI data word.
    typedef logic [WORD_LEN-1:0] word_t;

    // The SPI mode as its two classic bits.
    // cpol is the level of sck while idle.
    // cpha 0 samples on the first edge of a bit, cpha 1 on the second.
    typedef struct packed {
        logic cpol;  // Idle level of sck.
        logic cpha;  // Sampling edge select.
    } spi_mode_t;

    // A complete host command, latched as a whole when a frame starts.
    // Width is WORD_LEN + PRESC_W + 1 + 2, so 14 bits with the defaults.
    typedef struct packed {
        word_t              data;       // Word shifted out on mosi.
        logic [PRESC_W-1:0] presc;      // Half-period is 2**(presc+1) cycles.
        logic               lsb_first;  // Set to send bit 0 first.
        spi_mode_t          mode;       // Clock polarity and phase.
    } spi_cmd_t;

    // Mode and order of the bus stay with the command, not with the master.

endpackage

//--- design/spi_rx_port.sv
module spi_rx_port
    import spi_pkg::*;
(
    input  logic  wr,       // System clock.
    input  logic  rst,      // Asynchronous reset, active high.
    input  logic  rx_load,  // Engine hands over a finished word.
    input  word_t rx_word,  // The finished word.
    output logic  rx_full,  // Slot busy, from load until ack is back low.
    output logic  rx_req,   // Offer to the host, four-phase.
    input  logic  rx_ack,   // Host has taken the word.
    output word_t rx_data   // Word on offer, stable while rx_req is high.
);

    ////////////////////////////////////////////////////////////////////////////
    // Offer state

    typedef enum logic [1:0] {
        rx_empty,    // Free for the next word.
        rx_offer,    // rx_req high, waiting for the ack.
        rx_release   // rx_req dropped, waiting for the ack to fall.
    } rx_state_t;

    rx_state_t rx_state;
    word_t     data_q;

    always_ff @(posedge wr or posedge rst) begin
        if (rst) begin
            rx_state <= rx_empty;
        end else begin
            case (rx_state)
                rx_empty:   if (rx_load) rx_state <= rx_offer;    // Request next cycle.
                rx_offer:   if (rx_ack)  rx_state <= rx_release;  // Drop the request.
                rx_release: if (!rx_ack) rx_state <= rx_empty;
                default:    rx_state <= rx_empty;
            endcase
        end
    end

    // The engine only loads into an empty slot.
    always_ff @(posedge wr) begin
        if (rx_load) begin
            data_q <= rx_word;
        end
    end

    assign rx_full = (rx_state != rx_empty);
    assign rx_req  = (rx_state == rx_offer);
    assign rx_data = data_q;

endmodule

//--- design/spi_shift_engine.sv
module spi_shift_engine
    import spi_pkg::*;
(
    input  logic               wr,          // System clock.
    input  logic               rst,         // Asynchronous reset, active high.
    input  logic               cmd_valid,   // Command slot is full.
    input  spi_cmd_t           held_cmd,    // Command in the slot.
    output logic               cmd_take,    // Load held_cmd on this edge.
    input  logic               rx_full,     // Receive slot is busy.
    output logic               rx_load,     // Hand rx_word to the receive slot.
    output word_t              rx_word,     // Word assembled from miso.
    output logic               div_run,     // Run the half-period divider.
    output logic [PRESC_W-1:0] div_presc,   // Divider exponent for this frame.
    input  logic               half_tick,   // End of an sck half-period.
    output logic               ss,          // Slave select, active low.
    output logic               sck,         // SPI clock.
    output logic               mosi,        // Master out.
    input  logic               miso         // Master in.
);

    ////////////////////////////////////////////////////////////////////////////
    // Frame state

    typedef enum logic [1:0] {
        st_idle,   // ss high, nothing to send.
        st_shift,  // sck running, bits moving.
        st_done    // Word complete, waiting to hand it over.
    } eng_state_t;

    eng_state_t             state;
    spi_mode_t              mode_q;    // Mode of the current or last frame.
    logic                   lsb_q;     // Bit order of the current frame.
    logic [PRESC_W-1:0]     presc_q;   // Prescaler of the current frame.
    word_t                  tx_sh;     // Bits still to go out.
    word_t                  rx_sh;     // Bits gathered so far.
    logic [HALF_CNT_W-1:0]  hcnt;      // Half-period index within the frame.
    logic                   sck_q;     // sck before polarity is applied.
    logic                   ss_q;
    logic                   mosi_q;
    logic                   last_edge; // The sixteenth half-period ends now.
    logic                   sample_edge;
    logic                   shift_edge;

    // Leading bit of a word in the given order.
    function automatic logic lead_bit(input word_t w, input logic lsb);
        return lsb ? w[0] : w[WORD_LEN-1];
    endfunction

    // The word with its leading bit consumed. Ones fill the vacated end.
    function automatic word_t drop_bit(input word_t w, input logic lsb);
        return lsb ? {1'b1, w[WORD_LEN-1:1]} : {w[WORD_LEN-2:0], 1'b1};
    endfunction

    assign last_edge = (hcnt == HALF_CNT_W'(2 * WORD_LEN - 1));

    // hcnt[0] is 0 on the first edge of a bit and 1 on the second.
    // Sampling sits on the edge that matches cpha, shifting on the other one.
    assign sample_edge = (state == st_shift) && half_tick && (hcnt[0] == mode_q.cpha);
    assign shift_edge  = (state == st_shift) && half_tick && (hcnt[0] != mode_q.cpha)
                         && !last_edge;  // Nothing left to drive after bit 7.

    // A finished word waits in st_done until the receive slot is free, so no
    // word is ever overwritten. A new command starts only with that slot free.
    assign rx_load  = (state == st_done) && !rx_full;
    assign cmd_take = cmd_valid && !rx_full && ((state == st_idle) || (state == st_done));

    ////////////////////////////////////////////////////////////////////////////
    // Control registers

    always_ff @(posedge wr or posedge rst) begin
        if (rst) begin
            state  <= st_idle;
            ss_q   <= 1'b1;
            sck_q  <= 1'b0;
            hcnt   <= '0;
            mode_q <= '0;  // sck idles low after reset.
        end else if (cmd_take) begin
            state  <= st_shift;
            ss_q   <= 1'b0;           // Stays low on a back-to-back take.
            mode_q <= held_cmd.mode;
        end else if (rx_load) begin
            state <= st_idle;         // No follow-up command.
            ss_q  <= 1'b1;
        end else if ((state == st_shift) && half_tick) begin
            sck_q <= ~sck_q;          // Sixteen toggles leave it at rest.
            hcnt  <= hcnt + 1'b1;     // Wraps back to zero on the last edge.
            if (last_edge) begin
                state <= st_done;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Data path

    // Command fields are copied at take time so the host can reuse its port.
    always_ff @(posedge wr) begin
        if (cmd_take) begin
            presc_q <= held_cmd.presc;
            lsb_q   <= held_cmd.lsb_first;
            mosi_q  <= lead_bit(held_cmd.data, held_cmd.lsb_first);  // Ready for cpha 0.
            // With cpha 1 the first edge drives the first bit again.
            tx_sh   <= held_cmd.mode.cpha ? held_cmd.data
                                          : drop_bit(held_cmd.data, held_cmd.lsb_first);
        end else if (shift_edge) begin
            mosi_q <= lead_bit(tx_sh, lsb_q);
            tx_sh  <= drop_bit(tx_sh, lsb_q);
        end

        if (sample_edge) begin
            // The first bit in ends up in bit 7 for MSB first, in bit 0 otherwise.
            rx_sh <= lsb_q ? {miso, rx_sh[WORD_LEN-1:1]} : {rx_sh[WORD_LEN-2:0], miso};
        end
    end

    assign div_run   = (state == st_shift);
    assign div_presc = presc_q;
    assign rx_word   = rx_sh;
    assign ss        = ss_q;
    assign sck       = sck_q ^ mode_q.cpol;      // Idle level follows cpol.
    assign mosi      = ss_q ? 1'b1 : mosi_q;     // Held high while deselected.

endmodule

//--- tb/spi_slave_model.sv
module spi_slave_model
    import spi_pkg::*;
(
    input  logic wr,    // Sampling clock, the slave looks at the bus on its falling edge.
    input  logic ss,    // Slave select from the master.
    input  logic sck,   // SPI clock from the master.
    input  logic mosi,  // Data from the master.
    output logic miso   // Reply to the master.
);

    localparam int DEPTH = 32;  // Frames the model can track.

    // Per-frame setup, written by the testbench before the run starts.
    word_t reply_mem [DEPTH];  // Word sent back in each frame.
    logic  cpha_mem  [DEPTH];  // Clock phase of each frame.
    logic  lsb_mem   [DEPTH];  // Bit order of each frame.
    word_t cap_mem   [DEPTH];  // Word captured from mosi in each frame.

    int    fidx;      // Index of the current or next frame.
    int    edge_cnt;  // sck edges seen in the current frame.
    int    bit_idx;   // Position of the reply bit on miso.
    logic  in_frame;
    logic  prev_ss;
    logic  prev_sck;
    word_t cap_sh;    // mosi bits gathered so far.
    word_t cur_reply;
    logic  cur_lsb;

    assign cur_reply = reply_mem[fidx];
    assign cur_lsb   = lsb_mem[fidx];
    // Outside a frame the leading bit of the next reply is already on miso.
    assign miso = cur_lsb ? cur_reply[bit_idx] : cur_reply[WORD_LEN-1-bit_idx];

    initial begin
        fidx     = 0;
        edge_cnt = 0;
        bit_idx  = 0;
        in_frame = 1'b0;
        prev_ss  = 1'b1;
        prev_sck = 1'b0;
        cap_sh   = '0;
    end

    // An sck change only counts while ss was already low one cycle before.
    // That skips the polarity step that may come with the falling ss.
    always @(negedge wr) begin
        if (!ss && !prev_ss && (sck !== prev_sck)) begin
            if (!in_frame) begin
                in_frame = 1'b1;  // The first edge opens the frame.
                edge_cnt = 0;
            end
            if (edge_cnt[0] == cpha_mem[fidx]) begin
                // Sampling edge, same order rule as the master.
                cap_sh = cur_lsb ? {mosi, cap_sh[WORD_LEN-1:1]} : {cap_sh[WORD_LEN-2:0], mosi};
            end else if (cpha_mem[fidx]) begin
                bit_idx = edge_cnt / 2;        // cpha 1 drives on the first edge.
            end else if (edge_cnt < 2 * WORD_LEN - 1) begin
                bit_idx = (edge_cnt + 1) / 2;  // cpha 0 drives on the second edge.
            end
            edge_cnt++;
            if (edge_cnt == 2 * WORD_LEN) begin
                cap_mem[fidx] = cap_sh;  // Frame complete.
                fidx++;
                in_frame = 1'b0;
                bit_idx  = 0;
            end
        end
        prev_ss  = ss;
        prev_sck = sck;
    end

endmodule

//--- tb/tb_spi_master.sv
module tb_spi_master
    import spi_pkg::*;
;

    localparam int NUM_ROWS = 20;    // Rows in the test table.
    localparam int TIMEOUT  = 5000;  // Cycles allowed for any single wait.
    localparam int SEED     = 17543;

    // One test row. The flags say how the row is run and checked.
    typedef struct packed {
        spi_cmd_t    cmd;        // Command for the master.
        word_t       reply;      // Word the slave sends back.
        logic [15:0] ack_dly;    // Cycles before the host raises rx_ack.
        logic        wait_rx;    // Finish this row before the next command.
        logic        no_gap;     // ss must not rise before this frame.
        logic        stall_chk;  // cmd_ack must wait for an earlier frame to end.
    } row_t;

    logic     wr;
    logic     rst;
    logic     cmd_req;
    spi_cmd_t cmd;
    logic     cmd_ack;
    logic     rx_req;
    logic     rx_ack;
    word_t    rx_data;
    logic     ss;
    logic     sck;
    logic     mosi;
    logic     miso;

    row_t rows [NUM_ROWS];
    int   seed;
    int   errors;
    int   checks;
    int   done_cnt;                  // Rows fully received and acked.
    int   row_err;

    // Edge monitor state.
    int   mon_frame;
    int   mon_edges;
    int   mon_cycles;                // Cycles since the last sck edge.
    int   ss_rises;
    int   frame_rises [NUM_ROWS];    // ss rises counted at each frame start.
    logic mon_ss;
    logic mon_sck;

    spi_master UUT (
        .wr(wr), .rst(rst), .cmd_req(cmd_req), .cmd(cmd), .cmd_ack(cmd_ack),
        .rx_req(rx_req), .rx_ack(rx_ack), .rx_data(rx_data),
        .ss(ss), .sck(sck), .mosi(mosi), .miso(miso)
    );

    spi_slave_model u_slave (.wr(wr), .ss(ss), .sck(sck), .mosi(mosi), .miso(miso));

    initial wr = 1'b0;
    always #4 wr = ~wr;

    function automatic row_t make_row(input word_t data, input int presc, input logic lsb,
                                      input logic cpol, input logic cpha, input word_t reply,
                                      input int dly, input logic wait_rx, input logic no_gap,
                                      input logic stall_chk);
        row_t r;
        r.cmd.data      = data;
        r.cmd.presc     = PRESC_W'(presc);
        r.cmd.lsb_first = lsb;
        r.cmd.mode.cpol = cpol;
        r.cmd.mode.cpha = cpha;
        r.reply         = reply;
        r.ack_dly       = 16'(dly);
        r.wait_rx       = wait_rx;
        r.no_gap        = no_gap;
        r.stall_chk     = stall_chk;
        return r;
    endfunction

    // Cycles in one sck half-period, two to the power presc+1.
    function automatic int half_period_len(input int presc);
        int len;
        len = 1;
        for (int j = 0; j <= presc; j++) begin
            len = len * 2;
        end
        return len;
    endfunction

    task automatic stop_run(input string why);
        $display("Timeout: %s", why);
        $display("Test failures found");
        $finish;
    endtask

    task automatic await_cmd_ack(input logic level);
        int t;
        t = 0;
        while (cmd_ack !== level) begin
            @(posedge wr);
            t++;
            if (t > TIMEOUT) stop_run("cmd_ack never reached the expected level");
        end
    endtask

    task automatic await_rx_req(input logic level);
        int t;
        t = 0;
        while (rx_req !== level) begin
            @(posedge wr);
            t++;
            if (t > TIMEOUT) stop_run("rx_req never reached the expected level");
        end
    endtask

    task automatic await_done(input int count);
        int t;
        t = 0;
        while (done_cnt < count) begin
            @(posedge wr);
            t++;
            if (t > TIMEOUT) stop_run("a received word never completed its handshake");
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Host command side

    task automatic send_cmd(input int i);
        @(posedge wr);
        cmd     <= rows[i].cmd;
        cmd_req <= 1'b1;
        @(posedge wr);
        await_cmd_ack(1'b1);
        if (rows[i].stall_chk) begin
            checks++;
            // The slot only frees once the frame two rows back has finished.
            assert (mon_frame >= i - 1) else begin
                $display("[ERROR] row %0d: cmd_ack came early, frames done 0x%0h, expected 0x%0h",
                         i, mon_frame, i - 1);
                errors++;
            end
        end
        cmd_req <= 1'b0;
        @(posedge wr);
        await_cmd_ack(1'b0);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Host receive side

    task automatic receive_row(input int k);
        int e0;
        e0 = errors;
        await_rx_req(1'b1);
        checks += 2;
        assert (rx_data === rows[k].reply) else begin
            $display("[ERROR] row %0d: rx_data 0x%h, expected 0x%h", k, rx_data, rows[k].reply);
            errors++;
        end
        assert (u_slave.cap_mem[k] === rows[k].cmd.data) else begin
            $display("[ERROR] row %0d: mosi word 0x%h, expected 0x%h",
                     k, u_slave.cap_mem[k], rows[k].cmd.data);
            errors++;
        end
        if (rows[k].wait_rx) begin
            checks++;
            // Frame over and nothing queued, so the bus is idle.
            assert (ss === 1'b1 && sck === rows[k].cmd.mode.cpol) else begin
                $display("[ERROR] row %0d: ss 0x%h sck 0x%h, expected ss 0x1 sck 0x%h",
                         k, ss, sck, rows[k].cmd.mode.cpol);
                errors++;
            end
        end
        if (rows[k].no_gap) begin
            checks++;
            assert (frame_rises[k] == frame_rises[k-1]) else begin
                $display("ss went high between frames %0d and %0d", k - 1, k);
                errors++;
            end
        end
        repeat (rows[k].ack_dly) @(posedge wr);
        rx_ack <= 1'b1;
        @(posedge wr);
        await_rx_req(1'b0);
        rx_ack <= 1'b0;
        row_err = errors - e0;
        $display("row %0d: %s", k, (row_err == 0) ? "pass" : "FAIL");
        done_cnt++;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // sck edge monitor

    // Spacing between edges inside a frame is the full half-period.
    always @(negedge wr) begin
        mon_cycles++;
        if (ss === 1'b1 && mon_ss === 1'b0) begin
            ss_rises++;
            checks++;
            assert (mon_edges == 0) else begin
                $display("frame %0d ended after %0d sck edges", mon_frame, mon_edges);
                errors++;
            end
        end
        if (ss === 1'b0 && mon_ss === 1'b0 && sck !== mon_sck) begin
            if (mon_edges == 0) begin
                frame_rises[mon_frame] = ss_rises;
            end else begin
                checks++;
                assert (mon_cycles == half_period_len(rows[mon_frame].cmd.presc)) else begin
                    $display("[ERROR] frame %0d: sck spacing 0x%h, expected 0x%h", mon_frame,
                             mon_cycles, half_period_len(rows[mon_frame].cmd.presc));
                    errors++;
                end
            end
            mon_cycles = 0;
            mon_edges++;
            if (mon_edges == 2 * WORD_LEN) begin
                mon_edges = 0;
                mon_frame++;
            end
        end
        mon_ss  = ss;
        mon_sck = sck;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Main sequence

    initial begin
        rst       = 1'b1;
        cmd_req   = 1'b0;
        cmd       = '0;
        rx_ack    = 1'b0;
        seed      = SEED;
        errors    = 0;
        checks    = 0;
        done_cnt  = 0;
        mon_frame = 0;
        mon_edges = 0;
        mon_cycles = 0;
        ss_rises  = 0;
        mon_ss    = 1'b1;
        mon_sck   = 1'b0;

        // Four modes MSB first, then LSB first, then the prescaler sweep.
        rows[0]  = make_row(8'hA3, 1, 0, 0, 0, 8'h5C, 2, 1, 0, 0);
        rows[1]  = make_row(8'h1E, 1, 0, 0, 1, 8'hD2, 2, 1, 0, 0);
        rows[2]  = make_row(8'hC4, 1, 0, 1, 0, 8'h39, 2, 1, 0, 0);
        rows[3]  = make_row(8'h67, 1, 0, 1, 1, 8'h8B, 2, 1, 0, 0);
        rows[4]  = make_row(8'hC5, 0, 1, 0, 0, 8'h1D, 1, 1, 0, 0);
        rows[5]  = make_row(8'h3A, 1, 1, 0, 1, 8'hE0, 1, 1, 0, 0);
        rows[6]  = make_row(8'h96, 0, 1, 1, 0, 8'h4F, 1, 1, 0, 0);
        rows[7]  = make_row(8'h0D, 1, 1, 1, 1, 8'hB2, 1, 1, 0, 0);
        rows[8]  = make_row(8'h55, 0, 0, 0, 0, 8'hAA, 0, 1, 0, 0);
        rows[9]  = make_row(8'hF1, 2, 0, 0, 0, 8'h2E, 0, 1, 0, 0);
        rows[10] = make_row(8'h7C, 5, 0, 0, 0, 8'hC8, 0, 1, 0, 0);
        // Back to back with a prompt host.
        rows[11] = make_row(8'h12, 0, 0, 0, 1, 8'h34, 0, 0, 0, 0);
        rows[12] = make_row(8'h56, 0, 0, 0, 1, 8'h78, 0, 1, 1, 0);
        // Slow host; the third command has to wait for a free slot.
        rows[13] = make_row(8'h9A, 1, 0, 1, 0, 8'hBC, 300, 0, 0, 0);
        rows[14] = make_row(8'hDE, 1, 1, 1, 0, 8'hF0, 300, 0, 1, 0);
        rows[15] = make_row(8'h21, 1, 0, 1, 0, 8'h43, 0, 1, 1, 1);
        for (int i = 16; i < NUM_ROWS; i++) begin
            rows[i] = make_row(word_t'($random(seed)), $unsigned($random(seed)) % 3,
                               $random(seed), $random(seed), $random(seed),
                               word_t'($random(seed)), $unsigned($random(seed)) % 8, 1, 0, 0);
        end
        for (int i = 0; i < NUM_ROWS; i++) begin
            u_slave.reply_mem[i] = rows[i].reply;
            u_slave.cpha_mem[i]  = rows[i].cmd.mode.cpha;
            u_slave.lsb_mem[i]   = rows[i].cmd.lsb_first;
        end

        repeat (3) @(posedge wr);
        rst <= 1'b0;
        @(posedge wr);
        checks++;
        assert (ss === 1'b1 && mosi === 1'b1 && sck === 1'b0 && cmd_ack === 1'b0
                && rx_req === 1'b0) else begin
            $display("[ERROR] reset: ss 0x%h mosi 0x%h sck 0x%h cmd_ack 0x%h rx_req 0x%h",
                     ss, mosi, sck, cmd_ack, rx_req);
            errors++;
        end
        $display("reset: %s", (errors == 0) ? "pass" : "FAIL");

        fork
            begin
                for (int i = 0; i < NUM_ROWS; i++) begin
                    send_cmd(i);
                    if (rows[i].wait_rx) await_done(i + 1);
                end
            end
            begin
                for (int k = 0; k < NUM_ROWS; k++) receive_row(k);
            end
        join

        checks++;
        assert (mon_frame == NUM_ROWS) else begin
            $display("[ERROR] frame count 0x%h, expected 0x%h", mon_frame, NUM_ROWS);
            errors++;
        end
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule
